//--- logic/ram2ePkg.sv
`default_nettype none

package ram2ePkg;

    // Apple IIe phase number, 0 is the start-up state
    typedef logic [3:0] phaseT;

    localparam phaseT phaseIdle      = 4'd0;  // Start-up, waiting for PHI1
    localparam phaseT phaseVidAct    = 4'd2;  // Video row activate
    localparam phaseT phaseVidRead   = 4'd3;  // Video column read
    localparam phaseT phaseRefresh   = 4'd6;  // Refresh slot, video data valid
    localparam phaseT phaseRowLatch  = 4'd7;  // Card row address on Ain
    localparam phaseT phaseCardAct   = 4'd8;  // 80-column activate
    localparam phaseT phaseCardRw    = 4'd9;  // 80-column read or write
    localparam phaseT phaseBusSample = 4'd12; // CPU data valid

    // SDRAM command pins, all active low
    typedef struct packed {
        logic nCs;
        logic nRas;
        logic nCas;
        logic nWe;
    } sdramCmdT;

    localparam sdramCmdT cmdNop       = 4'b1111;
    localparam sdramCmdT cmdActive    = 4'b0011;
    localparam sdramCmdT cmdRead      = 4'b0101;
    localparam sdramCmdT cmdWrite     = 4'b0100;
    localparam sdramCmdT cmdRefresh   = 4'b0001;
    localparam sdramCmdT cmdPrecharge = 4'b0010;
    localparam sdramCmdT cmdModeSet   = 4'b0000;

    // Bank, row/column address and byte lane masks
    typedef struct packed {
        logic [1:0]  bank;
        logic [11:0] addr;
        logic        dqml;
        logic        dqmh;
    } sdramAddrT;

    // RAMWorks bank byte, raw from the bus or split into SDRAM fields
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic       highRow;   // Address bit 8 at column time
            logic       upperByte; // Upper DQ lane, +4MB
            logic [1:0] sdramBank;
            logic [3:0] rowHigh;   // Row address bits 11:8
        } fields;
    } bankWordT;

    // Single write, CAS latency 2, sequential, burst 1
    localparam logic [11:0] modeRegWord = 12'b0010_0010_0000;

    // Unlock sequence, element 0 comes first
    localparam logic [5:0][7:0] seqBytes = {8'hAD, 8'hC1, 8'hAA, 8'h55, 8'h00, 8'hFF};

    localparam logic [7:0] cmdMaskSet   = 8'hE0;
    localparam logic [7:0] cmdLedSet    = 8'hE2;
    localparam logic [7:0] cmdLedGet    = 8'hE3;
    localparam logic [7:0] cmdBankFfLed = 8'hF0;
    localparam logic [7:0] cmdBankFf    = 8'hFF;

endpackage

`default_nettype wire

//--- logic/phaseTimer.sv
`timescale 1ns/1ps
`default_nettype none

module phaseTimer #(
    parameter int InitBits = 16
) (
    input  wire                   C14M,
    input  wire                   rst,
    input  wire                   phi1,
    output ram2ePkg::phaseT       phase,
    output logic                  ready,
    output logic [InitBits-1:0]   initCount
);
    import ram2ePkg::*;

    localparam logic [InitBits-1:0] initEnd = '1; // Last start-up count

    logic phi1Sync; // PHI1 sampled on C14M
    logic phi1Last; // Previous sample, for edge detect
    logic phi1Rise;

    assign phi1Rise = phi1Sync && !phi1Last;

    // Free-running counter, also feeds the refresh divider later on
    always_ff @(posedge C14M) begin
        if (rst) begin
            initCount <= '0;
            ready <= 1'b0;
        end else begin
            initCount <= initCount + 1'b1;
            if (initCount == initEnd)
                ready <= 1'b1; // Init done, stays set
        end
    end

    always_ff @(posedge C14M) begin
        if (rst) begin
            phi1Sync <= 1'b0;
            phi1Last <= 1'b0;
        end else begin
            phi1Sync <= phi1;
            phi1Last <= phi1Sync;
        end
    end

    // Realign to phase 1 on every PHI1 rise
    // Counter parks at 15 if PHI1 is late, stays in 0 until ready
    always_ff @(posedge C14M) begin
        if (rst) begin
            phase <= phaseIdle;
        end else if (phi1Rise && ready) begin
            phase <= 4'd1;
        end else if (phase != phaseIdle && phase != 4'd15) begin
            phase <= phase + 4'd1;
        end
    end

endmodule

`default_nettype wire

//--- logic/bankControl.sv
`timescale 1ns/1ps
`default_nettype none

module bankControl (
    input  wire                C14M,
    input  wire                rst,
    input  wire ram2ePkg::phaseT phase,
    input  wire [7:0]          rowAddr,
    input  wire [7:0]          din,
    input  wire                nWe,
    input  wire                nC07x,
    output ram2ePkg::bankWordT bank,
    output logic               ledEn
);
    import ram2ePkg::*;

    logic       bankSel;     // Store to $C071/$C073 this Apple cycle
    logic [7:0] maskReg;     // Low seven bits held inverted
    logic [7:0] effMask;     // Mask applied to bank writes
    logic [2:0] seqState;    // Unlock sequence position
    logic [2:0] seqTimeout;  // Idle phase-12 passes
    logic       seqHit;      // Byte continues the sequence
    logic       selAccess;   // Bank register written this phase
    logic       pendFf;      // Force bank to FF next access
    logic       pendMaskSet;
    logic       pendLedSet;
    logic       pendLedGet;

    // Reset value 00 gives an effective mask of 7F
    assign effMask = {maskReg[7], ~maskReg[6:0]};

    // States 6 and 7 accept any byte
    assign seqHit = (seqState < 3'd6) ? (din == seqBytes[seqState]) : 1'b1;

    assign selAccess = (phase == phaseBusSample) && bankSel;

    // Address decode uses the row latched at phase 7
    always_ff @(posedge C14M) begin
        if (rst) begin
            bankSel <= 1'b0;
        end else if (phase == phaseCardRw) begin
            bankSel <= rowAddr[0] && !rowAddr[3] && !nWe && !nC07x;
        end
    end

    always_ff @(posedge C14M) begin
        if (rst) begin
            bank.raw <= 8'h00;
        end else if (selAccess) begin
            if (pendFf || (pendLedGet && ledEn))
                bank.raw <= 8'hFF; // Command reply or forced top bank
            else
                bank.raw <= din & effMask;
        end
    end

    // Sequence detector and command decode
    always_ff @(posedge C14M) begin
        if (rst) begin
            seqState <= 3'd0;
            seqTimeout <= 3'd0;
            pendFf <= 1'b0;
            pendMaskSet <= 1'b0;
            pendLedSet <= 1'b0;
            pendLedGet <= 1'b0;
        end else if (phase == phaseBusSample) begin
            if (bankSel) begin
                seqTimeout <= 3'd0;
                if (seqHit)
                    seqState <= seqState + 3'd1; // 7 wraps back to 0
                else
                    seqState <= 3'd0;

                // Command byte lands in state 6, one access only
                if (seqState == 3'd6) begin
                    pendFf <= (din == cmdBankFf) || (din == cmdBankFfLed);
                    pendMaskSet <= din == cmdMaskSet;
                    pendLedSet <= din == cmdLedSet;
                    pendLedGet <= din == cmdLedGet;
                end else begin
                    pendFf <= 1'b0;
                    pendMaskSet <= 1'b0;
                    pendLedSet <= 1'b0;
                    pendLedGet <= 1'b0;
                end
            end else begin
                seqTimeout <= seqTimeout + 3'd1;
                if (seqTimeout == 3'd7)
                    seqState <= 3'd0; // Eighth idle pass
            end
        end
    end

    // Settings applied on the access after the command byte
    always_ff @(posedge C14M) begin
        if (rst) begin
            maskReg <= 8'h00;
            ledEn <= 1'b0;
        end else if (selAccess) begin
            if (pendMaskSet)
                maskReg <= {din[7], ~din[6:0]}; // Effective mask becomes din
            if (pendLedSet)
                ledEn <= din[0];
        end
    end

endmodule

`default_nettype wire

//--- logic/sdramSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sdramSequencer #(
    parameter int InitBits = 16
) (
    input  wire                  C14M,
    input  wire                  rst,
    input  wire ram2ePkg::phaseT phase,
    input  wire                  ready,
    input  wire [InitBits-1:0]   initCount,
    input  wire [7:0]            ain,
    input  wire                  nEn80,
    input  wire                  nWe80,
    input  wire ram2ePkg::bankWordT bank,
    output ram2ePkg::sdramCmdT   sdramCmd,
    output ram2ePkg::sdramAddrT  sdramAddr,
    output logic                 cke,
    output logic [7:0]           rowAddr
);
    import ram2ePkg::*;

    // Start-up schedule, counted back from the last init count
    localparam logic [InitBits-1:0] initEnd      = '1;
    localparam logic [InitBits-1:0] ckeOnAt      = initEnd - InitBits'(255);
    localparam logic [InitBits-1:0] prechargeAt  = initEnd - InitBits'(63);
    localparam logic [InitBits-1:0] refreshAFrom = initEnd - InitBits'(47);
    localparam logic [InitBits-1:0] refreshATo   = initEnd - InitBits'(33);
    localparam logic [InitBits-1:0] modeSetAt    = initEnd - InitBits'(23);
    localparam logic [InitBits-1:0] refreshBFrom = initEnd - InitBits'(15);

    sdramCmdT  cmdNext;
    sdramAddrT addrNext;
    logic      ckeNext;
    logic      initRefresh; // Even counts in either refresh burst

    assign initRefresh = !initCount[0] &&
        ((initCount >= refreshAFrom && initCount <= refreshATo) ||
         initCount >= refreshBFrom);

    always_comb begin
        // Idle NOP, both lanes masked
        cmdNext = cmdNop;
        addrNext.bank = 2'b00;
        addrNext.addr = {4'h0, rowAddr};
        addrNext.dqml = 1'b1;
        addrNext.dqmh = 1'b1;
        ckeNext = 1'b1;

        if (phase == phaseIdle) begin
            ckeNext = ready || initCount >= ckeOnAt;
            addrNext.addr = modeRegWord; // Only sampled by mode set
            // Counter wraps after init, so the list runs once
            if (!ready) begin
                if (initCount == prechargeAt) begin
                    cmdNext = cmdPrecharge;
                    addrNext.addr[10] = 1'b1; // All banks
                end else if (initRefresh) begin
                    cmdNext = cmdRefresh;
                end else if (initCount == modeSetAt) begin
                    cmdNext = cmdModeSet;
                end
            end
        end else begin
            case (phase)
                phaseVidAct: begin
                    cmdNext = cmdActive; // Bank 0, row from phase 14/15
                end
                phaseVidRead: begin
                    cmdNext = cmdRead;
                    addrNext.addr = {4'b0100, ain}; // A10 auto-precharge
                    addrNext.dqml = 1'b0; // Video is always low lane
                end
                phaseRefresh: begin
                    if (initCount[5:4] == 2'b00)
                        cmdNext = cmdRefresh; // One Apple cycle in four
                end
                phaseCardAct: begin
                    cmdNext = cmdActive;
                    cmdNext.nCs = nEn80; // Only when the card is selected
                    addrNext.bank = bank.fields.sdramBank;
                    addrNext.addr = {bank.fields.rowHigh, rowAddr};
                    ckeNext = !nEn80;
                end
                phaseCardRw: begin
                    cmdNext = nWe80 ? cmdRead : cmdWrite;
                    cmdNext.nCs = nEn80;
                    addrNext.bank = bank.fields.sdramBank;
                    addrNext.addr = {3'b010, bank.fields.highRow, ain};
                    addrNext.dqml = bank.fields.upperByte;
                    addrNext.dqmh = !bank.fields.upperByte;
                    ckeNext = !nEn80;
                end
                4'd10: begin
                    ckeNext = !nEn80; // Card access still finishing
                end
                default: begin
                    ckeNext = phase < 4'd11; // Clock stopped 11 to 15
                end
            endcase
        end
    end

    always_ff @(posedge C14M) begin
        if (rst) begin
            sdramCmd <= cmdNop;
            sdramAddr.bank <= 2'b00;
            sdramAddr.addr <= 12'h000;
            sdramAddr.dqml <= 1'b1;
            sdramAddr.dqmh <= 1'b1;
            cke <= 1'b0;
        end else begin
            sdramCmd <= cmdNext;
            sdramAddr <= addrNext;
            cke <= ckeNext;
        end
    end

    // Row byte for card access at 7, for next video read at 14 and 15
    always_ff @(posedge C14M) begin
        if (rst) begin
            rowAddr <= 8'h00;
        end else if (phase == phaseRowLatch || phase == 4'd14 || phase == 4'd15) begin
            rowAddr <= ain;
        end
    end

endmodule

`default_nettype wire

//--- logic/busDrive.sv
`timescale 1ns/1ps
`default_nettype none

module busDrive (
    input  wire                  C14M,
    input  wire                  rst,
    input  wire ram2ePkg::phaseT phase,
    input  wire                  phi1,
    input  wire                  nEn80,
    input  wire                  nWe,
    input  wire                  nWe80,
    input  wire                  ledEn,
    input  wire [7:0]            din,
    inout  wire [7:0]            rd,
    output logic [7:0]           dout,
    output logic [7:0]           vout,
    output logic                 nDoe,
    output logic                 nVoe,
    output logic                 led
);
    import ram2ePkg::*;

    logic rdOe;  // Card write, drive SDRAM DQ
    logic doeEn; // Late half of the cycle, CPU bus may be driven

    assign rdOe = !nEn80 && !nWe80;
    assign rd = rdOe ? din : 8'hzz;

    // Window opens with phase 11 decoded, closes at phase 1
    always_ff @(posedge C14M) begin
        if (rst)
            doeEn <= 1'b0;
        else
            doeEn <= phase >= 4'd11;
    end

    assign nDoe = !(doeEn && !nEn80 && nWe); // CPU read of aux memory only
    assign nVoe = phi1; // Video bus owned during PHI0

    // Active low, lit on card access when enabled
    assign led = !(!nEn80 && ledEn);

    // Falling edge gives SDRAM data half a clock to settle
    always_ff @(negedge C14M) begin
        if (phase == phaseRefresh)
            vout <= rd; // Video read from phase 3
        if (phase == phaseBusSample)
            dout <= rd; // Card read from phase 9
    end

endmodule

`default_nettype wire

//--- logic/ram2eTop.sv
`timescale 1ns/1ps
`default_nettype none

module ram2eTop #(
    parameter int InitBits = 16 // Start-up counter width, at least 9
) (
    input  wire                 C14M,
    input  wire                 rst,
    input  wire                 phi1,
    input  wire                 nWe,
    input  wire                 nWe80,
    input  wire                 nEn80,
    input  wire                 nC07x,
    input  wire [7:0]           ain,
    input  wire [7:0]           din,
    inout  wire [7:0]           rd,
    output logic [7:0]          dout,
    output logic [7:0]          vout,
    output logic                nDoe,
    output logic                nVoe,
    output logic                led,
    output logic                cke,
    output ram2ePkg::sdramCmdT  sdramCmd,
    output ram2ePkg::sdramAddrT sdramAddr
);
    import ram2ePkg::*;

    phaseT                phase;
    logic                 ready;
    logic [InitBits-1:0]  initCount;
    logic [7:0]           rowAddr; // Row byte from the sequencer
    bankWordT             bank;
    logic                 ledEn;

    phaseTimer #(.InitBits(InitBits)) phaseTimer_i (
        .C14M(C14M), .rst(rst), .phi1(phi1),
        .phase(phase), .ready(ready), .initCount(initCount)
    );

    bankControl bankControl_i (
        .C14M(C14M), .rst(rst), .phase(phase), .rowAddr(rowAddr),
        .din(din), .nWe(nWe), .nC07x(nC07x),
        .bank(bank), .ledEn(ledEn)
    );

    sdramSequencer #(.InitBits(InitBits)) sdramSequencer_i (
        .C14M(C14M), .rst(rst), .phase(phase), .ready(ready),
        .initCount(initCount), .ain(ain), .nEn80(nEn80), .nWe80(nWe80),
        .bank(bank), .sdramCmd(sdramCmd), .sdramAddr(sdramAddr),
        .cke(cke), .rowAddr(rowAddr)
    );

    busDrive busDrive_i (
        .C14M(C14M), .rst(rst), .phase(phase), .phi1(phi1),
        .nEn80(nEn80), .nWe(nWe), .nWe80(nWe80), .ledEn(ledEn),
        .din(din), .rd(rd), .dout(dout), .vout(vout),
        .nDoe(nDoe), .nVoe(nVoe), .led(led)
    );

endmodule

`default_nettype wire

//--- test/ram2eAsserts_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module ram2eAsserts (
    input wire                     C14M,
    input wire                     rst,
    input wire                     cke,
    input wire ram2ePkg::sdramCmdT sdramCmd
);
    import ram2ePkg::*;

    // Clock enable off through reset
    ckeLowInReset: assert property (@(posedge C14M) rst |=> !cke)
        else $error("cke high after a reset cycle");

    // Video and card transfers both open the row first
    rwAfterActive: assert property (@(posedge C14M) disable iff (rst)
        (sdramCmd == cmdRead || sdramCmd == cmdWrite) |-> $past(sdramCmd) == cmdActive)
        else $error("SDRAM read or write without an activate before it");

    noCmdWithoutCke: assert property (@(posedge C14M) disable iff (rst) !cke |-> sdramCmd.nCs)
        else $error("SDRAM command issued while cke is low"); // Chip deselected

endmodule

bind sdramSequencer ram2eAsserts ram2eAsserts_i (
    .C14M(C14M), .rst(rst), .cke(cke), .sdramCmd(sdramCmd)
);

`default_nettype wire

//--- test/ram2eTb.sv
`timescale 1ns/1ps
`default_nettype none

module ram2eTb;
    import ram2ePkg::*;

    localparam int InitBits = 10;
    localparam int E = (1 << InitBits) - 1;               // Last start-up count
    localparam int CycleLimit = 16 + (E + 1) + 200 * 14;  // Reset, start-up, 200 Apple cycles

    typedef struct packed {
        logic      cke;
        sdramCmdT  cmd;
        sdramAddrT addr;
        sdramAddrT care; // Address bits that matter for this command
    } expT;

    logic C14M, rst, phi1, nWe, nWe80, nEn80, nC07x;
    logic [7:0] ain, din, dout, vout;
    wire  [7:0] rd;
    logic nDoe, nVoe, led, cke;
    sdramCmdT  sdramCmd;
    sdramAddrT sdramAddr;

    // Reference state that follows the card rules cycle by cycle
    logic [InitBits-1:0] cnt;
    logic [3:0] ph;
    logic rdy, p1s, p1l, doeM, selM, ledM, pFf, pMask, pLed, pGet;
    logic [7:0] rowM, bankM, maskM, rdData, vExp, dExp;
    logic [2:0] seqM, idleM;
    logic [31:0] seed = 32'ha44d_851b;
    int cycles = 0;
    int errors = 0;
    expT expOut;

    ram2eTop #(.InitBits(InitBits)) ram2eTop_i (.*);

    // SDRAM data model stays off the bus while the card writes
    assign rd = (ph >= 4'd3 && !(!nEn80 && !nWe80)) ? rdData : 8'hzz;

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected SDRAM pins one clock after the current decode
    function automatic expT refOut();
        expT e;
        e = '0;
        e.cke = 1'b1;
        e.cmd = cmdNop;
        if (rst) begin
            e.cke = 1'b0;
        end else if (ph == phaseIdle) begin
            e.cke = rdy || cnt >= E - 255;
            if (!rdy && cnt == E - 63) begin
                e.cmd = cmdPrecharge;
                e.addr.addr[10] = 1'b1; // All banks
                e.care.addr[10] = 1'b1;
            end else if (!rdy && !cnt[0] && ((cnt >= E - 47 && cnt <= E - 33) || cnt >= E - 15)) begin
                e.cmd = cmdRefresh;
            end else if (!rdy && cnt == E - 23) begin
                e.cmd = cmdModeSet;
                e.addr.addr = modeRegWord;
                e.care.addr = '1;
            end
        end else if (ph == phaseVidAct) begin
            e.cmd = cmdActive;
            e.addr = {2'b00, 4'h0, rowM, 2'b11}; // Row from the previous cycle's end
            e.care = '1;
        end else if (ph == phaseVidRead) begin
            e.cmd = cmdRead;
            e.addr = {2'b00, 4'b0100, ain, 2'b01}; // Auto-precharge on the low lane
            e.care = '1;
        end else if (ph == phaseRefresh && cnt[5:4] == 2'b00) begin
            e.cmd = cmdRefresh;
        end else if (ph == phaseCardAct) begin
            e.cke = !nEn80;
            e.cmd = cmdActive;
            e.cmd.nCs = nEn80;
            e.addr = {bankM[5:4], bankM[3:0], rowM, 2'b11};
            e.care = '1;
        end else if (ph == phaseCardRw) begin
            e.cke = !nEn80;
            e.cmd = nWe80 ? cmdRead : cmdWrite;
            e.cmd.nCs = nEn80;
            e.addr = {bankM[5:4], 3'b000, bankM[7], ain, bankM[6], !bankM[6]};
            e.care = {2'b11, 3'b000, 9'h1FF, 2'b11}; // Bank, A8, column, lanes
        end else if (ph == 4'd10) begin
            e.cke = !nEn80;
        end else if (ph >= 4'd11) begin
            e.cke = 1'b0; // SDRAM clock parked
        end
        return e;
    endfunction

    task automatic check(input logic ok, input string what);
        assert (ok) else begin
            errors++;
            $display("Mismatch at %0t ns: %s", $time, what);
            $display("Something failed");
            $fatal(1, "Stopped at first error");
        end
    endtask

    task automatic waitPhase(input logic [3:0] p);
        do @(posedge C14M); while (ph != p);
    endtask

    // Kind 0 video only, 1 card write, 2 card read, 3 store to $C071
    task automatic appleCycle(input int kind, input logic [7:0] data);
        waitPhase(4'd6);
        ain <= (kind == 3) ? 8'h71 : seed[7:0]; // Row byte latched at phase 7
        din <= data;
        nEn80 <= !(kind == 1 || kind == 2);
        nWe80 <= kind != 1;
        nWe <= !(kind == 1 || kind == 3);
        nC07x <= kind != 3;
        waitPhase(4'd8);
        ain <= seed[15:8]; // Card column
        waitPhase(4'd13);
        ain <= seed[23:16]; // Next video row
        waitPhase(4'd14);
        {nEn80, nWe80, nWe, nC07x} <= 4'hF;
        waitPhase(4'd2);
        ain <= seed[31:24]; // Video column
    endtask

    task automatic unlock(input logic [7:0] code, input logic [7:0] arg);
        for (int i = 0; i < 6; i++)
            appleCycle(3, seqBytes[i]);
        appleCycle(3, code);
        appleCycle(3, arg); // Access that applies the command
    endtask

    initial begin
        C14M = 1'b0;
        forever #4 C14M = ~C14M;
    end

    initial begin
        phi1 = 1'b0;
        forever begin
            repeat (7) @(posedge C14M);
            phi1 <= ~phi1;
        end
    end

    always @(posedge C14M) begin
        cycles <= cycles + 1;
        seed <= lcgNext(seed);
        rdData <= seed[23:16];
        expOut <= refOut();
        if (rst) begin
            {cnt, ph, rowM, bankM, seqM, idleM} <= '0;
            {rdy, p1s, p1l, doeM, selM, ledM, pFf, pMask, pLed, pGet} <= '0;
            maskM <= 8'h7F;
        end else begin
            cnt <= cnt + 1'b1;
            if (cnt == E)
                rdy <= 1'b1;
            p1s <= phi1;
            p1l <= p1s;
            if (p1s && !p1l && rdy)
                ph <= 4'd1;
            else if (ph != 4'd0 && ph != 4'd15)
                ph <= ph + 1'b1;
            doeM <= ph >= 4'd11;
            if (ph == phaseRowLatch || ph >= 4'd14)
                rowM <= ain;
            if (ph == phaseCardRw)
                selM <= rowM[0] && !rowM[3] && !nWe && !nC07x; // $C071/$C073 store
            if (ph == phaseBusSample && selM) begin
                bankM <= (pFf || (pGet && ledM)) ? 8'hFF : din & maskM;
                if (pMask)
                    maskM <= din;
                if (pLed)
                    ledM <= din[0];
                idleM <= 3'd0;
                seqM <= (seqM >= 3'd6 || din == seqBytes[seqM]) ? seqM + 1'b1 : 3'd0;
                {pFf, pMask, pLed, pGet} <= (seqM != 3'd6) ? 4'b0000 :
                    {din == cmdBankFf || din == cmdBankFfLed, din == cmdMaskSet,
                     din == cmdLedSet, din == cmdLedGet};
            end else if (ph == phaseBusSample) begin
                idleM <= idleM + 1'b1;
                if (idleM == 3'd7)
                    seqM <= 3'd0; // Eighth idle pass drops the sequence
            end
        end
        if (cycles == CycleLimit) begin
            $display("Timeout: run still busy after %0d clock cycles", cycles);
            $display("Something failed");
            $fatal(1, "Timeout");
        end
    end

    // Outputs settled half a clock after the rising edge
    always @(negedge C14M) begin
        if (cycles > 0) begin
            check(cke === expOut.cke, $sformatf("cke %b, expected %b", cke, expOut.cke));
            check(sdramCmd.nCs === expOut.cmd.nCs && (expOut.cmd.nCs || sdramCmd === expOut.cmd),
                $sformatf("SDRAM command %b, expected %b", sdramCmd, expOut.cmd));
            check(expOut.cmd.nCs || ((sdramAddr ^ expOut.addr) & expOut.care) === 16'h0,
                $sformatf("SDRAM address %h, expected %h", sdramAddr, expOut.addr));
            check(led === !(!nEn80 && ledM), "LED state");
            check(nDoe === !(doeM && !nEn80 && nWe), "nDoe");
            check(nVoe === phi1, "nVoe");
            check(nEn80 || nWe80 || rd === din, "write data on rd");
            if (ph == phaseRowLatch)
                check(vout === vExp, $sformatf("vout %h, expected %h", vout, vExp));
            if (ph == 4'd13)
                check(dout === dExp, $sformatf("dout %h, expected %h", dout, dExp));
        end
        if (ph == phaseRefresh)
            vExp <= rdData;
        if (ph == phaseBusSample)
            dExp <= (!nEn80 && !nWe80) ? din : rdData;
    end

    initial begin
        {nWe, nWe80, nEn80, nC07x} = 4'hF;
        ain = 8'h00;
        din = 8'h00;
        rst = 1'b1;
        repeat (16) @(posedge C14M);
        rst <= 1'b0;
        repeat (4) appleCycle(0, 8'h00);
        repeat (4) appleCycle(1, seed[7:0]);
        repeat (4) appleCycle(2, 8'h00);
        appleCycle(3, 8'hB5); // Plain bank store masked by 7F
        appleCycle(1, seed[15:8]);
        unlock(cmdMaskSet, 8'h1F);
        appleCycle(3, 8'hF6);
        appleCycle(1, seed[15:8]);
        unlock(cmdBankFfLed, 8'h12);
        appleCycle(1, seed[7:0]);
        appleCycle(2, 8'h00);
        unlock(cmdLedSet, 8'h01);
        appleCycle(2, 8'h00); // LED lit during the access
        unlock(cmdLedGet, 8'h00);
        appleCycle(1, seed[7:0]);
        // Partial sequence then eight idle cycles
        for (int i = 0; i < 3; i++)
            appleCycle(3, seqBytes[i]);
        repeat (8) appleCycle(0, 8'h00);
        for (int i = 3; i < 6; i++)
            appleCycle(3, seqBytes[i]);
        appleCycle(3, cmdMaskSet);
        appleCycle(3, 8'hE5); // Would be the new mask
        appleCycle(3, 8'hF6);
        appleCycle(1, seed[7:0]);
        repeat (14) @(posedge C14M);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
logic/ram2ePkg.sv
logic/phaseTimer.sv
logic/bankControl.sv
logic/sdramSequencer.sv
logic/busDrive.sv
logic/ram2eTop.sv
test/ram2eAsserts_asserts.sv
test/ram2eTb.sv

//--- Bender.yml
package:
  name: ram2e

sources:
  - logic/ram2ePkg.sv
  - logic/phaseTimer.sv
  - logic/bankControl.sv
  - logic/sdramSequencer.sv
  - logic/busDrive.sv
  - logic/ram2eTop.sv
  - target: test
    files:
      - test/ram2eAsserts_asserts.sv
      - test/ram2eTb.sv
